//--- periph_core.f
periph_bus_pkg.sv
periph_regs_pkg.sv
apb_bridge_fsm.sv
apb_splitter.sv
gpio_regs.sv
pwm_timer.sv
periph_core.sv
periph_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f periph_core.f \
	--top-module periph_core_tb -o sim_periph_core
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/sim_periph_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

//--- periph_core_tb.sv
// ======================================================================
// Self-checking testbench for the peripheral subsystem. Drives host
// request strobes into the DUT and checks GPIO, PWM, error and timing
// behavior with immediate assertions. Run through the file list.
// ======================================================================

`timescale 1ns/1ps

module periph_core_tb;

	import periph_bus_pkg::*;
	import periph_regs_pkg::*;

	localparam int N_PADS  = 11;
	localparam int TIMEOUT = 16; // Cycles to wait for a response

	logic              clk_sys;
	logic              reset;
	host_req_t         host_req;
	host_rsp_t         host_rsp;
	logic              busy;
	logic [N_PADS-1:0] padin;
	logic [N_PADS-1:0] padout;
	logic [N_PADS-1:0] padoe;
	logic              pwm_out;

	integer seed;
	int     checks;
	int     errors;
	int     tests;
	int     errors_at_start;

	// Captured by host_access
	logic [W_DATA-1:0] rsp_rdata;
	logic              rsp_err;
	int                rsp_latency;
	logic              rsp_busy_ok;
	logic              rsp_one_cycle;

	periph_core dut (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.host_req (host_req),
		.host_rsp (host_rsp),
		.busy     (busy),
		.padin    (padin),
		.padout   (padout),
		.padoe    (padoe),
		.pwm_out  (pwm_out)
	);

	always #10 clk_sys = ~clk_sys;

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic expect_eq(input string name, input logic [W_DATA-1:0] exp,
			input logic [W_DATA-1:0] act);
		checks++;
		assert (act === exp) else begin
			$display("Mismatch in %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic begin_test;
		errors_at_start = errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == errors_at_start)
			$display("Test %s: passed", name);
		else
			$display("Test %s: failed with %0d errors", name, errors - errors_at_start);
	endtask

	// One request strobe, then wait for the response strobe
	task automatic host_access(input string name, input bus_op_e op,
			input logic [W_PADDR-1:0] addr, input logic [W_DATA-1:0] wdata);
		int   cycles;
		logic seen;
		cycles         = 0;
		seen           = 1'b0;
		rsp_busy_ok    = 1'b1;
		host_req.valid = 1'b1;
		host_req.op    = op;
		host_req.addr  = addr;
		host_req.wdata = wdata;
		while (!seen && cycles < TIMEOUT) begin
			next_cycle();
			host_req.valid = 1'b0;
			cycles++;
			if (!busy)
				rsp_busy_ok = 1'b0; // Busy covers the response cycle too
			if (host_rsp.valid) begin
				seen      = 1'b1;
				rsp_rdata = host_rsp.rdata;
				rsp_err   = host_rsp.err;
			end
		end
		if (!seen) begin
			$display("Timeout in %s: no response within %0d cycles", name, TIMEOUT);
			errors++;
		end
		rsp_latency = cycles;
		next_cycle();
		rsp_one_cycle = !host_rsp.valid;
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		logic [W_DATA-1:0] out_val;
		logic [W_DATA-1:0] oe_val;
		logic [W_DATA-1:0] mask;
		logic [7:0]        duty;
		logic [1:0]        div_val;
		logic [3:0]        slot_nib;
		int                high_cnt;
		int                responses;

		seed     = 32'he2e99274;
		checks   = 0;
		errors   = 0;
		tests    = 0;
		clk_sys  = 1'b0;
		reset    = 1'b1;
		host_req = '0;
		padin    = '0;
		mask     = W_DATA'((1 << N_PADS) - 1);

		repeat (10) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		begin_test();
		expect_eq("reset valid", '0, W_DATA'(host_rsp.valid));
		expect_eq("reset busy", '0, W_DATA'(busy));
		expect_eq("reset padout", '0, W_DATA'(padout));
		expect_eq("reset padoe", '0, W_DATA'(padoe));
		expect_eq("reset pwm_out", '0, W_DATA'(pwm_out));
		end_test("reset_state");

		begin_test();
		out_val = $random(seed);
		oe_val  = $random(seed);
		host_access("gpio write out", OP_WRITE, GPIO_BASE + 16'(REG_GPIO_OUT), out_val);
		host_access("gpio write oe", OP_WRITE, GPIO_BASE + 16'(REG_GPIO_OE), oe_val);
		expect_eq("gpio padout", out_val & mask, W_DATA'(padout));
		expect_eq("gpio padoe", oe_val & mask, W_DATA'(padoe));
		host_access("gpio read out", OP_READ, GPIO_BASE + 16'(REG_GPIO_OUT), '0);
		expect_eq("gpio read out", out_val & mask, rsp_rdata);
		expect_eq("gpio read out err", '0, W_DATA'(rsp_err));
		host_access("gpio read oe", OP_READ, GPIO_BASE + 16'(REG_GPIO_OE), '0);
		expect_eq("gpio read oe", oe_val & mask, rsp_rdata);
		expect_eq("gpio read oe err", '0, W_DATA'(rsp_err));
		end_test("gpio_output");

		begin_test();
		padin = N_PADS'($random(seed));
		repeat (3) next_cycle(); // Two synchronizer stages plus margin
		host_access("gpio read in", OP_READ, GPIO_BASE + 16'(REG_GPIO_IN), '0);
		expect_eq("gpio read in", W_DATA'(padin), rsp_rdata);
		end_test("gpio_input");

		begin_test();
		duty    = 8'($random(seed));
		div_val = 2'($random(seed));
		host_access("pwm duty", OP_WRITE, PWM_BASE + 16'(REG_PWM_DUTY), W_DATA'(duty));
		host_access("pwm enable", OP_WRITE, PWM_BASE + 16'(REG_PWM_CTRL),
			{23'b0, 1'b1, 6'b0, div_val});
		repeat (4) next_cycle();
		high_cnt = 0;
		for (int i = 0; i < 256 * (int'(div_val) + 1); i++) begin
			if (pwm_out)
				high_cnt++;
			next_cycle();
		end
		expect_eq("pwm high cycles", W_DATA'(int'(duty) * (int'(div_val) + 1)),
			W_DATA'(high_cnt));
		host_access("pwm disable", OP_WRITE, PWM_BASE + 16'(REG_PWM_CTRL), '0);
		next_cycle();
		high_cnt = 0;
		for (int i = 0; i < 64; i++) begin
			if (pwm_out)
				high_cnt++;
			next_cycle();
		end
		expect_eq("pwm low after disable", '0, W_DATA'(high_cnt));
		end_test("pwm_duty");

		begin_test();
		slot_nib = 4'($unsigned($random(seed)) % 14) + 4'd2; // Slots 0x2 to 0xf
		// Same offset as GPIO OUT so a wrong slot decode shows up
		host_access("unmapped write", OP_WRITE, {slot_nib, REG_GPIO_OUT}, ~out_val);
		expect_eq("unmapped write err", 32'd1, W_DATA'(rsp_err));
		expect_eq("unmapped write rdata", '0, rsp_rdata);
		host_access("unmapped read", OP_READ, {slot_nib, REG_GPIO_OUT}, '0);
		expect_eq("unmapped read err", 32'd1, W_DATA'(rsp_err));
		expect_eq("unmapped read rdata", '0, rsp_rdata);
		host_access("gpio out unchanged", OP_READ, GPIO_BASE + 16'(REG_GPIO_OUT), '0);
		expect_eq("gpio out unchanged", out_val & mask, rsp_rdata);
		end_test("unmapped_address");

		begin_test();
		out_val = $random(seed);
		host_access("latency write", OP_WRITE, GPIO_BASE + 16'(REG_GPIO_OUT), out_val);
		expect_eq("latency cycles", 32'd3, W_DATA'(rsp_latency));
		expect_eq("busy while pending", 32'd1, W_DATA'(rsp_busy_ok));
		expect_eq("valid one cycle", 32'd1, W_DATA'(rsp_one_cycle));
		// Second strobe lands while the bridge is busy
		host_req.valid = 1'b1;
		host_req.op    = OP_WRITE;
		host_req.addr  = GPIO_BASE + 16'(REG_GPIO_OUT);
		host_req.wdata = out_val;
		next_cycle();
		host_req.wdata = ~out_val;
		next_cycle();
		host_req.valid = 1'b0;
		responses = 0;
		for (int i = 0; i < 8; i++) begin
			if (host_rsp.valid)
				responses++;
			next_cycle();
		end
		expect_eq("responses to two strobes", 32'd1, W_DATA'(responses));
		host_access("dropped write", OP_READ, GPIO_BASE + 16'(REG_GPIO_OUT), '0);
		expect_eq("dropped write", out_val & mask, rsp_rdata);
		end_test("latency_busy");

		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- periph_core.sv
// ======================================================================
// Peripheral subsystem top level. A host request port drives the bridge,
// which reaches the GPIO and backlight PWM through the splitter.
// ======================================================================

`timescale 1ns/1ps

module periph_core #(
	parameter int N_PADS    = 11,
	parameter int W_PWM_CTR = 8
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  periph_bus_pkg::host_req_t host_req,
	output periph_bus_pkg::host_rsp_t host_rsp,
	output logic                      busy,
	input  logic [N_PADS-1:0]         padin,
	output logic [N_PADS-1:0]         padout,
	output logic [N_PADS-1:0]         padoe,
	output logic                      pwm_out
);

	import periph_bus_pkg::*;
	import periph_regs_pkg::*;

	apb_req_t bridge_req;
	apb_rsp_t bridge_rsp;
	apb_req_t slot_req [N_SLOTS];
	apb_rsp_t slot_rsp [N_SLOTS];

	apb_bridge_fsm u_bridge (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.host_req (host_req),
		.host_rsp (host_rsp),
		.busy     (busy),
		.apb_req  (bridge_req),
		.apb_rsp  (bridge_rsp)
	);

	apb_splitter u_splitter (
		.apb_req  (bridge_req),
		.apb_rsp  (bridge_rsp),
		.slot_req (slot_req),
		.slot_rsp (slot_rsp)
	);

	gpio_regs #(
		.N_PADS (N_PADS)
	) u_gpio (
		.clk_sys (clk_sys),
		.reset   (reset),
		.apb_req (slot_req[SLOT_GPIO]),
		.apb_rsp (slot_rsp[SLOT_GPIO]),
		.padin   (padin),
		.padout  (padout),
		.padoe   (padoe)
	);

	pwm_timer #(
		.W_PWM_CTR (W_PWM_CTR)
	) u_pwm (
		.clk_sys (clk_sys),
		.reset   (reset),
		.apb_req (slot_req[SLOT_PWM]),
		.apb_rsp (slot_rsp[SLOT_PWM]),
		.pwm_out (pwm_out)
	);

endmodule

//--- pwm_timer.sv
// ======================================================================
// Backlight PWM. A prescaler steps a free-running counter every div+1
// cycles; the output is high while the count is below DUTY.
// Program DUTY and DIV, then set EN.
// ======================================================================

`timescale 1ns/1ps

module pwm_timer #(
	parameter int W_PWM_CTR = 8
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  periph_bus_pkg::apb_req_t apb_req,
	output periph_bus_pkg::apb_rsp_t apb_rsp,
	output logic                     pwm_out
);

	import periph_bus_pkg::*;
	import periph_regs_pkg::*;

	logic [11:0]          offset;
	logic                 wen;
	pwm_ctrl_t            ctrl_q;
	logic [W_PWM_CTR-1:0] duty_q;
	logic [7:0]           presc_q;
	logic [W_PWM_CTR-1:0] ctr_q;

	assign offset = apb_req.paddr[11:0];
	assign wen    = apb_req.psel && apb_req.penable && apb_req.pwrite;

	// ==================================================================
	// Registers
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ctrl_q <= '0;
		end else if (wen && offset == REG_PWM_CTRL) begin
			ctrl_q <= pwm_ctrl_t'(apb_req.pwdata[$bits(pwm_ctrl_t)-1:0]);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wen && offset == REG_PWM_DUTY)
			duty_q <= apb_req.pwdata[W_PWM_CTR-1:0];
	end

	always_comb begin
		apb_rsp.pslverr = 1'b0;
		case (offset)
			REG_PWM_CTRL: apb_rsp.prdata = W_DATA'(ctrl_q);
			REG_PWM_DUTY: apb_rsp.prdata = W_DATA'(duty_q);
			default:      apb_rsp.prdata = '0;
		endcase
	end

	// ==================================================================
	// Counter and compare
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (reset || !ctrl_q.en) begin
			presc_q <= '0;
			ctr_q   <= '0;
			pwm_out <= 1'b0;
		end else begin
			if (presc_q == ctrl_q.div) begin
				presc_q <= '0;
				ctr_q   <= ctr_q + 1'b1; // Wraps after 2^W_PWM_CTR steps
			end else begin
				presc_q <= presc_q + 1'b1;
			end
			pwm_out <= (ctr_q < duty_q);
		end
	end

endmodule

//--- gpio_regs.sv
// ======================================================================
// GPIO pad registers on the peripheral bus. OUT and OE drive the pads,
// IN reads back the pads through a two-flop synchronizer.
// ======================================================================

`timescale 1ns/1ps

module gpio_regs #(
	parameter int N_PADS = 11
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  periph_bus_pkg::apb_req_t apb_req,
	output periph_bus_pkg::apb_rsp_t apb_rsp,
	input  logic [N_PADS-1:0]        padin,
	output logic [N_PADS-1:0]        padout,
	output logic [N_PADS-1:0]        padoe
);

	import periph_bus_pkg::*;
	import periph_regs_pkg::*;

	logic [11:0]       offset;
	logic              wen;
	logic [N_PADS-1:0] out_q;
	logic [N_PADS-1:0] oe_q;
	logic [N_PADS-1:0] in_meta;
	logic [N_PADS-1:0] in_q;

	assign offset = apb_req.paddr[11:0];
	assign wen    = apb_req.psel && apb_req.penable && apb_req.pwrite;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out_q <= '0;
			oe_q  <= '0;
		end else if (wen) begin
			case (offset)
				REG_GPIO_OUT: out_q <= apb_req.pwdata[N_PADS-1:0];
				REG_GPIO_OE:  oe_q  <= apb_req.pwdata[N_PADS-1:0];
				default:      ; // IN and holes ignore writes
			endcase
		end
	end

	// Pads are asynchronous to clk_sys
	always_ff @(posedge clk_sys) begin
		in_meta <= padin;
		in_q    <= in_meta;
	end

	always_comb begin
		apb_rsp.pslverr = 1'b0;
		case (offset)
			REG_GPIO_OUT: apb_rsp.prdata = W_DATA'(out_q);
			REG_GPIO_OE:  apb_rsp.prdata = W_DATA'(oe_q);
			REG_GPIO_IN:  apb_rsp.prdata = W_DATA'(in_q);
			default:      apb_rsp.prdata = '0;
		endcase
	end

	assign padout = out_q;
	assign padoe  = oe_q;

endmodule

//--- apb_splitter.sv
// ======================================================================
// Peripheral bus address splitter. Routes each transfer to the slave
// whose 4 KiB slot matches, and flags an error for unmapped addresses.
// ======================================================================

`timescale 1ns/1ps

module apb_splitter (
	input  periph_bus_pkg::apb_req_t apb_req,
	output periph_bus_pkg::apb_rsp_t apb_rsp,
	output periph_bus_pkg::apb_req_t slot_req [periph_regs_pkg::N_SLOTS],
	input  periph_bus_pkg::apb_rsp_t slot_rsp [periph_regs_pkg::N_SLOTS]
);

	import periph_bus_pkg::*;
	import periph_regs_pkg::*;

	logic [15:0]        slot_addr;
	logic [N_SLOTS-1:0] hit;

	assign slot_addr = apb_req.paddr & SLOT_MASK;

	assign hit[SLOT_GPIO] = (slot_addr == GPIO_BASE);
	assign hit[SLOT_PWM]  = (slot_addr == PWM_BASE);

	// Slaves see the full address, but only the hit one is selected
	always_comb begin
		for (int i = 0; i < N_SLOTS; i++) begin
			slot_req[i]         = apb_req;
			slot_req[i].psel    = apb_req.psel && hit[i];
			slot_req[i].penable = apb_req.penable && hit[i];
		end
	end

	// Slots are one-hot, so OR-ing the gated responses is a mux
	always_comb begin
		apb_rsp.prdata  = '0;
		apb_rsp.pslverr = ~|hit; // Nothing mapped here
		for (int i = 0; i < N_SLOTS; i++) begin
			if (hit[i]) begin
				apb_rsp.prdata  = apb_rsp.prdata | slot_rsp[i].prdata;
				apb_rsp.pslverr = apb_rsp.pslverr | slot_rsp[i].pslverr;
			end
		end
	end

endmodule

//--- apb_bridge_fsm.sv
// ======================================================================
// Host to peripheral bus bridge. Each accepted request strobe becomes
// one setup and one access phase; the response strobe follows a cycle
// later. Requests seen while busy are dropped.
// ======================================================================

`timescale 1ns/1ps

module apb_bridge_fsm (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  periph_bus_pkg::host_req_t host_req,
	output periph_bus_pkg::host_rsp_t host_rsp,
	output logic                      busy,
	output periph_bus_pkg::apb_req_t  apb_req,
	input  periph_bus_pkg::apb_rsp_t  apb_rsp
);

	import periph_bus_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		ACCESS,
		RESPOND
	} state_e;

	state_e             state;
	bus_op_e            op_q;
	logic [W_PADDR-1:0] addr_q;
	logic [W_DATA-1:0]  wdata_q;
	logic [W_DATA-1:0]  rdata_q;
	logic               err_q;

	// ==================================================================
	// State sequencing
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:    state <= host_req.valid ? SETUP : IDLE;
				SETUP:   state <= ACCESS;
				ACCESS:  state <= RESPOND; // Every slave completes here
				default: state <= IDLE;
			endcase
		end
	end

	// Request is latched on acceptance, response at the end of access
	always_ff @(posedge clk_sys) begin
		if (state == IDLE && host_req.valid) begin
			op_q    <= host_req.op;
			addr_q  <= host_req.addr;
			wdata_q <= host_req.wdata;
		end
		if (state == ACCESS) begin
			rdata_q <= apb_rsp.prdata;
			err_q   <= apb_rsp.pslverr;
		end
	end

	// ==================================================================
	// Outputs
	// ==================================================================

	always_comb begin
		apb_req.psel    = (state == SETUP) || (state == ACCESS);
		apb_req.penable = (state == ACCESS);
		apb_req.pwrite  = (op_q == OP_WRITE);
		apb_req.paddr   = addr_q;
		apb_req.pwdata  = wdata_q;

		host_rsp.valid  = (state == RESPOND);
		host_rsp.err    = err_q;
		host_rsp.rdata  = rdata_q;
	end

	assign busy = (state != IDLE);

endmodule

//--- periph_regs_pkg.sv
// ======================================================================
// Address map of the peripheral bus and register layouts of the slaves.
// ======================================================================

package periph_regs_pkg;

	// 4 KiB slots, decoded from the top nibble of paddr
	localparam logic [15:0] SLOT_MASK = 16'hf000;
	localparam logic [15:0] GPIO_BASE = 16'h0000;
	localparam logic [15:0] PWM_BASE  = 16'h1000;

	localparam int N_SLOTS = 2;

	typedef enum logic {
		SLOT_GPIO = 1'b0,
		SLOT_PWM  = 1'b1
	} slot_e;

	// GPIO register offsets within the slot
	localparam logic [11:0] REG_GPIO_OUT = 12'h000;
	localparam logic [11:0] REG_GPIO_OE  = 12'h004;
	localparam logic [11:0] REG_GPIO_IN  = 12'h008; // Read only

	// PWM register offsets within the slot
	localparam logic [11:0] REG_PWM_CTRL = 12'h000;
	localparam logic [11:0] REG_PWM_DUTY = 12'h004;

	// CTRL: en in bit 8, prescale divider in bits 7:0
	typedef struct packed {
		logic       en;
		logic [7:0] div;
	} pwm_ctrl_t;

endpackage

//--- periph_bus_pkg.sv
// ======================================================================
// Peripheral bus types shared by the bridge, the splitter and the slaves.
// Modules import this inside their body and use scoped names on ports.
// ======================================================================

package periph_bus_pkg;

	localparam int W_PADDR = 16;
	localparam int W_DATA  = 32;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_e;

	// Host side, single-cycle strobes in both directions
	typedef struct packed {
		logic               valid;
		bus_op_e            op;
		logic [W_PADDR-1:0] addr;
		logic [W_DATA-1:0]  wdata;
	} host_req_t;

	typedef struct packed {
		logic              valid;
		logic              err;
		logic [W_DATA-1:0] rdata;
	} host_rsp_t;

	// Two-phase peripheral bus, no wait states
	typedef struct packed {
		logic               psel;
		logic               penable;
		logic               pwrite;
		logic [W_PADDR-1:0] paddr;
		logic [W_DATA-1:0]  pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [W_DATA-1:0] prdata;
		logic              pslverr;
	} apb_rsp_t;

endpackage
